// File: hdl/issue_pkg.sv
// Shared definitions for the issue stage
// Data, register index and ROB tag widths
// Functional unit latencies and countdown width
// Opcode and controller state enums

package issue_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // Data word width
    localparam int unsigned XLEN       = 32;
    // Register index width and register count
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;
    // ROB tag width, the tags wrap after 32 issues
    localparam int unsigned TAG_W      = 5;

    // ==================================================
    // Latencies
    // ==================================================

    // Cycles from issue to writeback for each kind of operation
    localparam int unsigned LAT_ALU = 1;
    localparam int unsigned LAT_MUL = 3;
    localparam int unsigned LAT_DIV = 8;
    // CSR operations run on the ALU timer with their own latency
    localparam int unsigned LAT_CSR = 2;
    // Countdown width, wide enough for the longest latency
    localparam int unsigned LAT_W   = 4;

    // Kind of the incoming instruction
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_DIV,
        OP_CSR,
        OP_FENCE
    } opcode_t;

    // Issue controller states
    typedef enum logic [1:0] {
        ST_RUN,
        ST_CSR_WAIT,
        ST_FENCE_WAIT
    } issue_state_t;

endpackage

// File: hdl/register_file.sv
// Integer register file
// 32 registers with two asynchronous read ports and one synchronous write port

module register_file import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_a_i,
    input  logic [REG_ADDR_W-1:0] raddr_b_i,
    output logic [XLEN-1:0]       rdata_a_o,
    output logic [XLEN-1:0]       rdata_b_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    // Write port, register x0 is never written
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Both read ports are combinational
    // The zero register is forced here so it never depends on the array contents
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: hdl/fu_timer.sv
// Scoreboard entry for one functional unit
// Busy flag, remaining-cycle countdown and destination register

module fu_timer import issue_pkg::*; #(
    // Cycles from issue to writeback for this unit
    parameter int unsigned LATENCY = LAT_ALU
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  start_i,
    // High when the operation being started is a CSR access
    input  logic                  op_is_csr_i,
    input  logic [REG_ADDR_W-1:0] dest_i,
    output logic                  busy_o,
    output logic [LAT_W-1:0]      remain_o,
    output logic [REG_ADDR_W-1:0] dest_o
);

    logic [LAT_W-1:0]      count_q;
    logic [LAT_W-1:0]      load_val;
    logic [REG_ADDR_W-1:0] dest_q;

    // CSR accesses share the ALU timer but take longer
    assign load_val = op_is_csr_i ? LAT_W'(LAT_CSR) : LAT_W'(LATENCY);

    // ==================================================
    // Countdown
    // ==================================================

    // A start is also legal in the last cycle of the previous operation,
    // the new value simply replaces the count of 1
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= load_val;
        end else if (count_q != '0) begin
            count_q <= count_q - LAT_W'(1);
        end
    end

    // Destination of the running operation
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            dest_q <= dest_i;
        end
    end

    // A count of 1 marks the writeback cycle of the running operation
    assign busy_o   = (count_q != '0);
    assign remain_o = count_q;
    assign dest_o   = dest_q;

endmodule

// File: hdl/issue_ctrl.sv
// Issue controller
// RAW, structural and writeback collision checks against the scoreboard
// CSR and fence serialization FSM
// Start pulses for the unit timers and the ROB tag counter

module issue_ctrl import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  instr_valid_i,
    input  opcode_t               instr_op_i,
    input  logic [REG_ADDR_W-1:0] src1_i,
    input  logic [REG_ADDR_W-1:0] src2_i,
    input  logic [REG_ADDR_W-1:0] dest_i,
    input  logic                  imm_valid_i,
    // Scoreboard state of the three units
    input  logic                  alu_busy_i,
    input  logic [LAT_W-1:0]      alu_remain_i,
    input  logic [REG_ADDR_W-1:0] alu_dest_i,
    input  logic                  mul_busy_i,
    input  logic [LAT_W-1:0]      mul_remain_i,
    input  logic [REG_ADDR_W-1:0] mul_dest_i,
    input  logic                  div_busy_i,
    input  logic [LAT_W-1:0]      div_remain_i,
    input  logic [REG_ADDR_W-1:0] div_dest_i,
    output logic                  stall_o,
    output logic                  alu_start_o,
    output logic                  mul_start_o,
    output logic                  div_start_o,
    output logic                  accept_o,
    output logic [TAG_W-1:0]      tag_o
);

    issue_state_t     state_q, state_d;
    logic [TAG_W-1:0] tag_q;
    logic [LAT_W-1:0] new_lat;
    logic             is_fence, is_csr, uses_src2;
    logic             any_busy, raw_hit, struct_hit, coll_hit, state_hit;
    logic             accept;

    // True when a unit will still be writing its destination after this cycle
    // At count 1 the writeback is in flight and forwarding covers it
    function automatic logic raw_check(input logic                  busy,
                                       input logic [LAT_W-1:0]      remain,
                                       input logic [REG_ADDR_W-1:0] dest,
                                       input logic [REG_ADDR_W-1:0] src1,
                                       input logic [REG_ADDR_W-1:0] src2,
                                       input logic                  use2);
        logic match;
        match = (dest == src1) || (use2 && (dest == src2));
        return busy && (dest != '0) && (remain > LAT_W'(1)) && match;
    endfunction

    // Two results would share the writeback port in the same cycle
    function automatic logic coll_check(input logic             busy,
                                        input logic [LAT_W-1:0] remain,
                                        input logic [LAT_W-1:0] lat);
        return busy && ((remain - LAT_W'(1)) == lat);
    endfunction

    assign is_fence  = (instr_op_i == OP_FENCE);
    assign is_csr    = (instr_op_i == OP_CSR);
    // A fence reads nothing and an immediate replaces the second source
    assign uses_src2 = !imm_valid_i && !is_fence;
    assign any_busy  = alu_busy_i || mul_busy_i || div_busy_i;

    // Latency of the incoming operation
    // A fence has none
    always_comb begin
        case (instr_op_i)
            OP_ALU:  new_lat = LAT_W'(LAT_ALU);
            OP_MUL:  new_lat = LAT_W'(LAT_MUL);
            OP_DIV:  new_lat = LAT_W'(LAT_DIV);
            OP_CSR:  new_lat = LAT_W'(LAT_CSR);
            default: new_lat = '0;
        endcase
    end

    // ==================================================
    // Hazard checks
    // ==================================================

    assign raw_hit = !is_fence && (
        raw_check(alu_busy_i, alu_remain_i, alu_dest_i, src1_i, src2_i, uses_src2) ||
        raw_check(mul_busy_i, mul_remain_i, mul_dest_i, src1_i, src2_i, uses_src2) ||
        raw_check(div_busy_i, div_remain_i, div_dest_i, src1_i, src2_i, uses_src2));

    // Each unit takes one operation at a time
    always_comb begin
        case (instr_op_i)
            OP_ALU, OP_CSR: struct_hit = alu_busy_i && (alu_remain_i > LAT_W'(1));
            OP_MUL:         struct_hit = mul_busy_i && (mul_remain_i > LAT_W'(1));
            OP_DIV:         struct_hit = div_busy_i && (div_remain_i > LAT_W'(1));
            default:        struct_hit = 1'b0;
        endcase
    end

    assign coll_hit = !is_fence && (
        coll_check(alu_busy_i, alu_remain_i, new_lat) ||
        coll_check(mul_busy_i, mul_remain_i, new_lat) ||
        coll_check(div_busy_i, div_remain_i, new_lat));

    // A running CSR blocks everything
    // A fence waits for every unit to drain
    assign state_hit = (state_q == ST_CSR_WAIT) ||
                       ((is_fence || (state_q == ST_FENCE_WAIT)) && any_busy);

    // Nothing is taken in while the scoreboard is being flushed
    assign stall_o = instr_valid_i &&
                     (flush_i || raw_hit || struct_hit || coll_hit || state_hit);
    assign accept  = instr_valid_i && !stall_o;

    assign accept_o    = accept;
    assign alu_start_o = accept && ((instr_op_i == OP_ALU) || is_csr);
    assign mul_start_o = accept && (instr_op_i == OP_MUL);
    assign div_start_o = accept && (instr_op_i == OP_DIV);

    // ==================================================
    // Serialization FSM
    // ==================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (accept && is_csr) begin
                    state_d = ST_CSR_WAIT;
                end else if (instr_valid_i && is_fence && any_busy) begin
                    state_d = ST_FENCE_WAIT;
                end
            end
            // Leave on the edge where the CSR timer frees
            ST_CSR_WAIT: begin
                if (alu_remain_i <= LAT_W'(1)) begin
                    state_d = ST_RUN;
                end
            end
            // The held fence is accepted in the cycle the units are all idle
            ST_FENCE_WAIT: begin
                if (!any_busy) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // The ROB tag advances on every issue and never on a fence
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            tag_q <= '0;
        end else if (accept && !is_fence) begin
            tag_q <= tag_q + TAG_W'(1);
        end
    end

    // Tag of the instruction being presented
    assign tag_o = tag_q;

endmodule

// File: hdl/operand_select.sv
// Operand selection and issue register
// Immediate, forwarded writeback or register file data per operand
// Registered issue outputs with op, destination and ROB tag

module operand_select import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  accept_i,
    input  opcode_t               instr_op_i,
    input  logic [XLEN-1:0]       rdata_a_i,
    input  logic [XLEN-1:0]       rdata_b_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic [REG_ADDR_W-1:0] src1_i,
    input  logic [REG_ADDR_W-1:0] src2_i,
    input  logic [REG_ADDR_W-1:0] wb_reg_i,
    input  logic [REG_ADDR_W-1:0] dest_i,
    input  logic                  imm_valid_i,
    input  logic                  wb_valid_i,
    input  logic [TAG_W-1:0]      tag_i,
    output logic                  issue_valid_o,
    output opcode_t               issue_op_o,
    output logic [REG_ADDR_W-1:0] issue_dest_o,
    output logic [TAG_W-1:0]      issue_tag_o,
    output logic [XLEN-1:0]       operand_a_o,
    output logic [XLEN-1:0]       operand_b_o
);

    logic            fwd_a, fwd_b;
    logic            do_issue;
    logic [XLEN-1:0] op_a, op_b;

    // A writeback to x0 carries nothing and must never be forwarded
    assign fwd_a = wb_valid_i && (wb_reg_i != '0) && (wb_reg_i == src1_i);
    assign fwd_b = wb_valid_i && (wb_reg_i != '0) && (wb_reg_i == src2_i);

    // Immediate first (B only), then the writeback of this cycle, then the array
    assign op_a = fwd_a ? wb_data_i : rdata_a_i;
    assign op_b = imm_valid_i ? imm_i : (fwd_b ? wb_data_i : rdata_b_i);

    // A fence is accepted but never reaches the execution units
    assign do_issue = accept_i && (instr_op_i != OP_FENCE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= do_issue;
        end
    end

    // Payload only changes on an issue
    always_ff @(posedge clk_i) begin
        if (do_issue) begin
            issue_op_o   <= instr_op_i;
            issue_dest_o <= dest_i;
            issue_tag_o  <= tag_i;
            operand_a_o  <= op_a;
            operand_b_o  <= op_b;
        end
    end

endmodule

// File: hdl/issue_stage.sv
// Issue stage top level
// Register file, ALU / MUL / DIV scoreboard timers, issue controller
// and operand selector

module issue_stage import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Decoded instruction, held by the source while stall_o is high
    input  logic                  instr_valid_i,
    input  opcode_t               instr_op_i,
    input  logic [REG_ADDR_W-1:0] src1_i,
    input  logic [REG_ADDR_W-1:0] src2_i,
    input  logic [REG_ADDR_W-1:0] dest_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  imm_valid_i,
    output logic                  stall_o,
    // Writeback from the execution units
    input  logic                  wb_valid_i,
    input  logic [REG_ADDR_W-1:0] wb_reg_i,
    input  logic [XLEN-1:0]       wb_data_i,
    // Issued instruction, valid for one cycle
    output logic                  issue_valid_o,
    output opcode_t               issue_op_o,
    output logic [REG_ADDR_W-1:0] issue_dest_o,
    output logic [TAG_W-1:0]      issue_tag_o,
    output logic [XLEN-1:0]       operand_a_o,
    output logic [XLEN-1:0]       operand_b_o
);

    logic [XLEN-1:0]       rdata_a, rdata_b;
    logic                  alu_start, mul_start, div_start, accept;
    logic                  alu_busy, mul_busy, div_busy;
    logic [LAT_W-1:0]      alu_remain, mul_remain, div_remain;
    logic [REG_ADDR_W-1:0] alu_dest, mul_dest, div_dest;
    logic [TAG_W-1:0]      tag;
    // The ALU timer loads the CSR latency for a CSR access
    wire                   op_is_csr = (instr_op_i == OP_CSR);

    register_file regfile_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_valid_i),
        .waddr_i   (wb_reg_i),
        .wdata_i   (wb_data_i),
        .raddr_a_i (src1_i),
        .raddr_b_i (src2_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    // ==================================================
    // Scoreboard
    // ==================================================

    fu_timer #(.LATENCY(LAT_ALU)) alu_timer (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .start_i     (alu_start),
        .op_is_csr_i (op_is_csr),
        .dest_i      (dest_i),
        .busy_o      (alu_busy),
        .remain_o    (alu_remain),
        .dest_o      (alu_dest)
    );

    fu_timer #(.LATENCY(LAT_MUL)) mul_timer (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .start_i     (mul_start),
        .op_is_csr_i (1'b0),
        .dest_i      (dest_i),
        .busy_o      (mul_busy),
        .remain_o    (mul_remain),
        .dest_o      (mul_dest)
    );

    fu_timer #(.LATENCY(LAT_DIV)) div_timer (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .start_i     (div_start),
        .op_is_csr_i (1'b0),
        .dest_i      (dest_i),
        .busy_o      (div_busy),
        .remain_o    (div_remain),
        .dest_o      (div_dest)
    );

    issue_ctrl ctrl_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_op_i    (instr_op_i),
        .src1_i        (src1_i),
        .src2_i        (src2_i),
        .dest_i        (dest_i),
        .imm_valid_i   (imm_valid_i),
        .alu_busy_i    (alu_busy),
        .alu_remain_i  (alu_remain),
        .alu_dest_i    (alu_dest),
        .mul_busy_i    (mul_busy),
        .mul_remain_i  (mul_remain),
        .mul_dest_i    (mul_dest),
        .div_busy_i    (div_busy),
        .div_remain_i  (div_remain),
        .div_dest_i    (div_dest),
        .stall_o       (stall_o),
        .alu_start_o   (alu_start),
        .mul_start_o   (mul_start),
        .div_start_o   (div_start),
        .accept_o      (accept),
        .tag_o         (tag)
    );

    operand_select opsel_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .accept_i      (accept),
        .instr_op_i    (instr_op_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .imm_i         (imm_i),
        .wb_data_i     (wb_data_i),
        .src1_i        (src1_i),
        .src2_i        (src2_i),
        .wb_reg_i      (wb_reg_i),
        .dest_i        (dest_i),
        .imm_valid_i   (imm_valid_i),
        .wb_valid_i    (wb_valid_i),
        .tag_i         (tag),
        .issue_valid_o (issue_valid_o),
        .issue_op_o    (issue_op_o),
        .issue_dest_o  (issue_dest_o),
        .issue_tag_o   (issue_tag_o),
        .operand_a_o   (operand_a_o),
        .operand_b_o   (operand_b_o)
    );

endmodule

// File: sim/issue_stage_props.sv
// Concurrent assertions on the issue controller
// Handshake exclusivity and scoreboard start rules

module issue_ctrl_props import issue_pkg::*; (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             stall_o,
    input logic             alu_start_o,
    input logic             mul_start_o,
    input logic             div_start_o,
    input logic             alu_busy_i,
    input logic             mul_busy_i,
    input logic             div_busy_i,
    input logic [LAT_W-1:0] alu_remain_i,
    input logic [LAT_W-1:0] mul_remain_i,
    input logic [LAT_W-1:0] div_remain_i,
    input issue_state_t     state_q
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled instruction never starts a unit
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(stall_o && alu_start_o))
        else $error("stall_o and alu_start_o high together");

    // One instruction per cycle means one start per cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({alu_start_o, mul_start_o, div_start_o}))
        else $error("more than one unit started in a cycle");

    // A unit may be restarted only in its writeback cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(alu_start_o && alu_busy_i && (alu_remain_i > LAT_W'(1))))
        else $error("ALU started while busy");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mul_start_o && mul_busy_i && (mul_remain_i > LAT_W'(1))))
        else $error("MUL started while busy");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(div_start_o && div_busy_i && (div_remain_i > LAT_W'(1))))
        else $error("DIV started while busy");

    // The CSR wait only lasts while the CSR runs on the ALU timer
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == ST_CSR_WAIT) |-> alu_busy_i)
        else $error("CSR wait with an idle ALU timer");

endmodule

bind issue_ctrl issue_ctrl_props props_i (.*);

// File: sim/issue_stage_tb.sv
// Testbench for the issue stage
// Clock, reset, directed and random stimulus, execution unit model
// Reference function, typed compare tasks and the result line

module issue_stage_tb import issue_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk_i = 1'b0;
    logic rst_n_i, flush_i, instr_valid_i, imm_valid_i, wb_valid_i, stall_o, issue_valid_o;
    opcode_t instr_op_i, issue_op_o;
    logic [REG_ADDR_W-1:0] src1_i, src2_i, dest_i, wb_reg_i, issue_dest_o;
    logic [XLEN-1:0] imm_i, wb_data_i, operand_a_o, operand_b_o;
    logic [TAG_W-1:0] issue_tag_o;

    // Expected issues, pending writebacks and the shadow register array
    opcode_t         exp_op_q[$];
    logic [TAG_W-1:0] exp_tag_q[$];
    logic [REG_ADDR_W-1:0] exp_dest_q[$];
    logic [XLEN-1:0] exp_a_q[$], exp_b_q[$], wb_dat_q[$];
    logic [REG_ADDR_W-1:0] wb_reg_q[$];
    int              wb_due_q[$];
    logic [XLEN-1:0] shadow[NUM_REGS];
    logic [TAG_W-1:0] exp_tag;
    int cycle = 0, errors = 0, csr_due = -1, last_div = -100;

    issue_stage issue_stage_i (.*);

    always #20 clk_i = ~clk_i;

    // Result an execution unit would produce for the given operands
    function automatic logic [XLEN-1:0] exec_result(opcode_t op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b);
        case (op)
            OP_ALU:  return a + b;
            OP_MUL:  return a * b;
            OP_DIV:  return (b == '0) ? '1 : a / b;
            default: return a;
        endcase
    endfunction

    function automatic int op_latency(opcode_t op);
        case (op)
            OP_MUL:  return LAT_MUL;
            OP_DIV:  return LAT_DIV;
            OP_CSR:  return LAT_CSR;
            default: return LAT_ALU;
        endcase
    endfunction

    task automatic check_operand(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(logic [TAG_W-1:0] got, logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: tag is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(logic [REG_ADDR_W-1:0] got, logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: destination is x%0d, expected x%0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_op(opcode_t got, opcode_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: op is %s, expected %s", $time, got.name(), exp.name());
            errors++;
        end
    endtask

    // ==================================================
    // Execution unit model
    // ==================================================

    // Drives every result due in this cycle and updates the shadow array
    always begin
        int hits;
        @(posedge clk_i);
        cycle++;
        #2;
        hits = 0;
        wb_valid_i = 1'b0;
        for (int i = wb_due_q.size() - 1; i >= 0; i--) begin
            if (wb_due_q[i] == cycle) begin
                hits++;
                wb_valid_i = 1'b1;
                wb_reg_i   = wb_reg_q[i];
                wb_data_i  = wb_dat_q[i];
                if (wb_reg_q[i] != '0) shadow[wb_reg_q[i]] = wb_dat_q[i];
                wb_due_q.delete(i);
                wb_reg_q.delete(i);
                wb_dat_q.delete(i);
            end
        end
        if (hits > 1) begin
            $display("[ERROR] %0t: %0d results share the writeback port", $time, hits);
            errors++;
        end
    end

    // Compare the issue of this cycle, then record what the next edge accepts
    always @(negedge clk_i) begin
        logic [XLEN-1:0] a, b;
        if (issue_valid_o) begin
            if (exp_op_q.size() == 0) begin
                $display("Unexpected issue at %0t with nothing accepted", $time);
                errors++;
            end else begin
                check_op(issue_op_o, exp_op_q.pop_front());
                check_tag(issue_tag_o, exp_tag_q.pop_front());
                check_dest(issue_dest_o, exp_dest_q.pop_front());
                check_operand("operand A", operand_a_o, exp_a_q.pop_front());
                check_operand("operand B", operand_b_o, exp_b_q.pop_front());
                if (issue_op_o == OP_DIV) begin
                    if (cycle - last_div < LAT_DIV - 1) begin
                        $display("[ERROR] %0t: DIV issued %0d cycles after the previous one",
                                 $time, cycle - last_div);
                        errors++;
                    end
                    last_div = cycle;
                end
            end
        end
        if (rst_n_i && !flush_i && instr_valid_i && !stall_o) begin
            if (cycle + 1 <= csr_due) begin
                $display("[ERROR] %0t: instruction accepted before CSR writeback", $time);
                errors++;
            end
            if (instr_op_i != OP_FENCE) begin
                a = (src1_i == '0) ? '0 : shadow[src1_i];
                b = imm_valid_i ? imm_i : ((src2_i == '0) ? '0 : shadow[src2_i]);
                exp_op_q.push_back(instr_op_i);
                exp_tag_q.push_back(exp_tag);
                exp_dest_q.push_back(dest_i);
                exp_a_q.push_back(a);
                exp_b_q.push_back(b);
                exp_tag = exp_tag + TAG_W'(1);
                // Accepted at edge E, written back in the cycle after E+L-1
                wb_due_q.push_back(cycle + op_latency(instr_op_i));
                wb_reg_q.push_back(dest_i);
                wb_dat_q.push_back(exec_result(instr_op_i, a, b));
                if (instr_op_i == OP_CSR) csr_due = cycle + LAT_CSR;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Presents one instruction and holds it until the stage takes it
    task automatic issue_instr(opcode_t op, int s1, int s2, int d, logic [XLEN-1:0] imm,
                               logic iv);
        int n;
        n = 0;
        instr_valid_i = 1'b1;
        instr_op_i    = op;
        src1_i        = REG_ADDR_W'(s1);
        src2_i        = REG_ADDR_W'(s2);
        dest_i        = REG_ADDR_W'(d);
        imm_i         = imm;
        imm_valid_i   = iv;
        @(negedge clk_i);
        while (stall_o && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= 50) begin
            $display("Timeout: %s stalled for 50 cycles", op.name());
            errors++;
        end
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
    endtask

    // Waits until every expected issue and writeback has happened
    task automatic drain();
        int n;
        n = 0;
        while ((exp_op_q.size() != 0 || wb_due_q.size() != 0) && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= 50) begin
            $display("Timeout: issues or writebacks still pending after 50 cycles");
            errors++;
        end
        @(posedge clk_i);
        #2;
    endtask

    initial begin
        int r;
        void'($urandom(51436));
        foreach (shadow[i]) shadow[i] = '0;
        exp_tag = '0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i = OP_ALU;
        src1_i = '0;
        src2_i = '0;
        dest_i = '0;
        imm_i = '0;
        imm_valid_i = 1'b0;
        wb_valid_i = 1'b0;
        wb_reg_i = '0;
        wb_data_i = '0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // Fill the registers, then read them back in pairs, with x0 and immediates
        for (int i = 1; i < 32; i++) issue_instr(OP_ALU, 0, 0, i, $urandom, 1'b1);
        for (int i = 0; i < 32; i++) issue_instr(OP_ALU, i, 31 - i, 0, '0, 1'b0);
        issue_instr(OP_ALU, 0, 5, 0, 32'h1234_5678, 1'b1);
        drain();

        // Dependents right behind MUL and DIV producers
        issue_instr(OP_MUL, 1, 2, 3, '0, 1'b0);
        issue_instr(OP_ALU, 3, 0, 4, '0, 1'b0);
        issue_instr(OP_DIV, 4, 2, 5, '0, 1'b0);
        issue_instr(OP_MUL, 5, 5, 6, '0, 1'b0);
        issue_instr(OP_DIV, 7, 0, 8, '0, 1'b0);
        drain();

        // Back-to-back DIVs, then tag wrap and flush
        issue_instr(OP_DIV, 1, 2, 9, '0, 1'b0);
        issue_instr(OP_DIV, 3, 4, 10, '0, 1'b0);
        issue_instr(OP_ALU, 9, 10, 11, '0, 1'b0);
        for (int i = 0; i < 34; i++) issue_instr(OP_ALU, i % 32, 1, 12, '0, 1'b0);
        drain();
        flush_i = 1'b1;
        exp_tag = '0;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        issue_instr(OP_ALU, 1, 2, 13, '0, 1'b0);

        // CSR serialization and a fence behind long operations
        issue_instr(OP_CSR, 13, 0, 14, '0, 1'b0);
        issue_instr(OP_ALU, 14, 1, 15, '0, 1'b0);
        issue_instr(OP_DIV, 15, 2, 16, '0, 1'b0);
        issue_instr(OP_MUL, 16, 3, 17, '0, 1'b0);
        issue_instr(OP_FENCE, 0, 0, 0, '0, 1'b0);
        issue_instr(OP_ALU, 16, 17, 18, '0, 1'b0);
        drain();

        // Random mix
        for (int i = 0; i < 200; i++) begin
            r = $urandom % 10;
            issue_instr(r < 4 ? OP_ALU : r < 6 ? OP_MUL : r < 7 ? OP_DIV :
                        r < 9 ? OP_CSR : OP_FENCE,
                        $urandom % 32, $urandom % 32, $urandom % 32, $urandom, $urandom % 2);
        end
        drain();

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/issue_pkg.sv
hdl/register_file.sv
hdl/fu_timer.sv
hdl/issue_ctrl.sv
hdl/operand_select.sv
hdl/issue_stage.sv
sim/issue_stage_props.sv
sim/issue_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module issue_stage_tb -o sim_issue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_issue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi
